//--- bus_subsystem.f
bus_pkg.sv
bus_arbiter.sv
mem_sequencer.sv
resp_router.sv
bus_subsystem.sv
tb_mem_model.sv
tb_bus_subsystem.sv

//--- Makefile
TOP  := tb_bus_subsystem
SRCS := $(shell cat bus_subsystem.f)

all: run

obj_dir/V$(TOP): bus_subsystem.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f bus_subsystem.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- tb_bus_subsystem.sv
/* testbench for the two-core memory bus
   directed tests and random traffic checked against per-space reference memories */
`timescale 1ns/1ps

module tb_bus_subsystem;
    import bus_pkg::*;

    localparam int NUM_OPS     = 54;
    localparam int RESET_CYC   = 10;
    localparam int WATCHDOG_NS = NUM_OPS * 40 * 4 + RESET_CYC * 4;
    localparam int ACK_LIMIT   = 400;

    logic        CLK;
    logic        arst_n;
    logic        init_done;
    logic        req0, req1;
    op_t         op0, op1;
    addr_t       addr0, addr1;
    data_t       wdata0, wdata1;
    dram_ctrl_t  ctrl0, ctrl1;
    logic        ack0, ack1;
    data_t       rdata0, rdata1;
    addr_t       mem_addr;
    data_t       mem_wdata;
    dram_ctrl_t  dram_ctrl;
    logic        dram_le, dram_we, dat_le, dat_we;
    logic        dram_busy, dat_busy;
    data_t       dram_rdata, dat_rdata;
    core_id_t    grant;
    logic        grant_valid;
    dram_ctrl_t  last_ctrl;
    logic [1:0]  busy_len;
    logic [15:0] busy_st;
    logic [15:0] stim_st;
    logic [31:0] busy_bits;

    data_t ref_dram [8];
    data_t ref_dat [8];

    bus_subsystem dut (.*);

    tb_mem_model mem (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic draw(inout logic [15:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], st[0]};
            st = lfsr_next(st);
        end
    endtask

    initial begin
        busy_st  = 16'd49;
        busy_len = 2'd0;
        forever begin
            @(negedge CLK);
            draw(busy_st, 2, busy_bits);
            busy_len = busy_bits[1:0];
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_core(input string name, input core_id_t got, input core_id_t exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_ctrl(input string name, input dram_ctrl_t got, input dram_ctrl_t exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic wait_ack(input core_id_t c, input logic level);
        int n;
        n = 0;
        while (((c == 1'b1) ? ack1 : ack0) !== level) begin
            @(negedge CLK);
            n++;
            if (n > ACK_LIMIT) begin
                report_failure($sformatf("core %0d ack did not reach %0b within %0d cycles",
                                         c, level, ACK_LIMIT));
            end
        end
    endtask

    // full four-phase cycle on one core port
    task automatic issue_op(input core_id_t c, input op_t op, input addr_t a, input data_t wd,
                            input dram_ctrl_t ctl, input int hold, output data_t rd);
        data_t exp;
        @(negedge CLK);
        if (c == 1'b1) begin
            op1    = op;
            addr1  = a;
            wdata1 = wd;
            ctrl1  = ctl;
            req1   = 1'b1;
        end else begin
            op0    = op;
            addr0  = a;
            wdata0 = wd;
            ctrl0  = ctl;
            req0   = 1'b1;
        end
        wait_ack(c, 1'b1);
        rd = (c == 1'b1) ? rdata1 : rdata0;
        // ack order is memory order
        if (op[0]) begin
            check_data($sformatf("rdata%0d", c), rd, '0);
            if (op[1]) begin
                ref_dat[a[2:0]] = wd;
            end else begin
                ref_dram[a[2:0]] = wd;
            end
        end else begin
            exp = op[1] ? ref_dat[a[2:0]] : ref_dram[a[2:0]];
            check_data($sformatf("rdata%0d", c), rd, exp);
        end
        repeat (hold) @(negedge CLK);
        if (c == 1'b1) begin
            req1 = 1'b0;
        end else begin
            req0 = 1'b0;
        end
        wait_ack(c, 1'b0);
    endtask

    task automatic test_reset_init();
        data_t rd;
        if (ack0 || ack1) report_failure("ack high after reset");
        if (grant_valid) report_failure("grant_valid high after reset");
        if (dram_le || dram_we || dat_le || dat_we) report_failure("strobe high after reset");
        fork
            issue_op(1'b0, OP_DRAM_WR, 32'd7, 32'h1234_5678, 3'd1, 0, rd);
            begin
                repeat (20) begin
                    @(negedge CLK);
                    if (dram_le || dram_we || dat_le || dat_we || ack0 || ack1) begin
                        report_failure("bus activity while init_done was low");
                    end
                end
                init_done = 1'b1;
            end
        join
    endtask

    task automatic test_dram_core0();
        data_t rd;
        issue_op(1'b0, OP_DRAM_WR, 32'd3, 32'hCAFE_0003, 3'd5, 0, rd);
        check_ctrl("last_ctrl", last_ctrl, 3'd5);
        issue_op(1'b0, OP_DRAM_RD, 32'd3, '0, 3'd2, 0, rd);
        check_ctrl("last_ctrl", last_ctrl, 3'd2);
        check_data("rdata0", rd, 32'hCAFE_0003);
    endtask

    task automatic test_data_core1();
        data_t rd;
        issue_op(1'b1, OP_DATA_WR, 32'd2, 32'hDA7A_0002, 3'd0, 0, rd);
        issue_op(1'b1, OP_DRAM_WR, 32'd2, 32'hD4A3_0002, 3'd0, 0, rd);
        issue_op(1'b1, OP_DATA_RD, 32'd2, '0, 3'd0, 0, rd);
        check_data("rdata1", rd, 32'hDA7A_0002);
        issue_op(1'b1, OP_DRAM_RD, 32'd2, '0, 3'd0, 0, rd);
        check_data("rdata1", rd, 32'hD4A3_0002);
    endtask

    // both cores request on the same edge
    task automatic contend(input core_id_t first);
        data_t r0, r1;
        repeat (4) @(negedge CLK);
        fork
            issue_op(1'b0, OP_DRAM_RD, 32'd3, '0, 3'd0, 0, r0);
            issue_op(1'b1, OP_DATA_RD, 32'd2, '0, 3'd0, 0, r1);
            begin
                while (!grant_valid) @(negedge CLK);
                check_core("grant", grant, first);
                while (!(ack0 || ack1)) @(negedge CLK);
                check_core("first ack", core_id_t'(ack1), first);
            end
        join
    endtask

    task automatic test_round_robin();
        data_t rd;
        contend(1'b0);
        issue_op(1'b0, OP_DRAM_WR, 32'd1, 32'h0B0B_0001, 3'd4, 0, rd);
        contend(1'b1);
    endtask

    task automatic test_back_pressure();
        data_t r0, r1;
        repeat (4) @(negedge CLK);
        fork
            issue_op(1'b0, OP_DRAM_RD, 32'd1, '0, 3'd0, 30, r0);
            begin
                repeat (3) @(negedge CLK);
                issue_op(1'b1, OP_DATA_RD, 32'd2, '0, 3'd0, 0, r1);
            end
            begin
                while (!ack0) @(negedge CLK);
                while (ack0) begin
                    if (ack1) report_failure("ack1 rose while ack0 was still held");
                    @(negedge CLK);
                end
            end
        join
        check_data("rdata1", rdata1, ref_dat[2]);
        // core 0 data kept across the core 1 result
        check_data("rdata0", rdata0, ref_dram[1]);
    endtask

    task automatic test_random();
        logic [31:0] v;
        core_id_t    rc [40];
        op_t         ro [40];
        addr_t       ra [40];
        data_t       rw [40];
        dram_ctrl_t  rcl [40];
        data_t       r0, r1;
        int          q0 [$];
        int          q1 [$];
        for (int i = 0; i < 40; i++) begin
            draw(stim_st, 1, v);
            rc[i] = v[0];
            draw(stim_st, 2, v);
            ro[i] = v[1:0];
            draw(stim_st, 3, v);
            ra[i] = {29'd0, v[2:0]};
            draw(stim_st, 32, v);
            rw[i] = v;
            draw(stim_st, 3, v);
            rcl[i] = v[2:0];
            if (rc[i] == 1'b1) begin
                q1.push_back(i);
            end else begin
                q0.push_back(i);
            end
        end
        repeat (4) @(negedge CLK);
        fork
            foreach (q0[j]) begin
                issue_op(1'b0, ro[q0[j]], ra[q0[j]], rw[q0[j]], rcl[q0[j]], 0, r0);
            end
            foreach (q1[j]) begin
                issue_op(1'b1, ro[q1[j]], ra[q1[j]], rw[q1[j]], rcl[q1[j]], 0, r1);
            end
        join
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the tests finished");
    end

    initial begin
        arst_n    = 1'b0;
        init_done = 1'b0;
        req0      = 1'b0;
        req1      = 1'b0;
        op0       = OP_DRAM_RD;
        op1       = OP_DRAM_RD;
        addr0     = '0;
        addr1     = '0;
        wdata0    = '0;
        wdata1    = '0;
        ctrl0     = '0;
        ctrl1     = '0;
        stim_st   = 16'd49;
        for (int i = 0; i < 8; i++) begin
            ref_dram[i] = '0;
            ref_dat[i]  = '0;
        end
        repeat (RESET_CYC) @(posedge CLK);
        @(negedge CLK);
        arst_n = 1'b1;
        test_reset_init();
        test_dram_core0();
        test_data_core1();
        test_round_robin();
        test_back_pressure();
        test_random();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- tb_mem_model.sv
/* behavioral memory targets for the bus testbench
   dram and data space, each with a strobe/busy handshake and an 8-word array */
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic [1:0]            busy_len,
    input  bus_pkg::addr_t        mem_addr,
    input  bus_pkg::data_t        mem_wdata,
    input  bus_pkg::dram_ctrl_t   dram_ctrl,
    input  logic                  dram_le,
    input  logic                  dram_we,
    input  logic                  dat_le,
    input  logic                  dat_we,
    output logic                  dram_busy,
    output logic                  dat_busy,
    output bus_pkg::data_t        dram_rdata,
    output bus_pkg::data_t        dat_rdata,
    output bus_pkg::dram_ctrl_t   last_ctrl
);
    import bus_pkg::*;

    data_t      dram_mem [8];
    data_t      dat_mem [8];
    logic [1:0] dram_cnt;
    logic [1:0] dat_cnt;

    // busy stays high for busy_len + 1 cycles
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            dram_busy  <= 1'b0;
            dram_cnt   <= 2'd0;
            dram_rdata <= '0;
            last_ctrl  <= '0;
            for (int i = 0; i < 8; i++) begin
                dram_mem[i] <= '0;
            end
        end else if (dram_busy) begin
            if (dram_cnt == 2'd0) begin
                dram_busy <= 1'b0;
            end else begin
                dram_cnt <= dram_cnt - 2'd1;
            end
        end else if (dram_le || dram_we) begin
            dram_busy <= 1'b1;
            dram_cnt  <= busy_len;
            last_ctrl <= dram_ctrl;
            if (dram_we) begin
                dram_mem[mem_addr[2:0]] <= mem_wdata;
            end else begin
                dram_rdata <= dram_mem[mem_addr[2:0]];
            end
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            dat_busy  <= 1'b0;
            dat_cnt   <= 2'd0;
            dat_rdata <= '0;
            for (int i = 0; i < 8; i++) begin
                dat_mem[i] <= '0;
            end
        end else if (dat_busy) begin
            if (dat_cnt == 2'd0) begin
                dat_busy <= 1'b0;
            end else begin
                dat_cnt <= dat_cnt - 2'd1;
            end
        end else if (dat_le || dat_we) begin
            dat_busy <= 1'b1;
            dat_cnt  <= busy_len;
            if (dat_we) begin
                dat_mem[mem_addr[2:0]] <= mem_wdata;
            end else begin
                dat_rdata <= dat_mem[mem_addr[2:0]];
            end
        end
    end

endmodule

//--- bus_subsystem.sv
/* two-core shared memory bus
   arbiter, memory sequencer and response router in a three-stage pipeline */
`timescale 1ns/1ps

module bus_subsystem (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic                  init_done,
    input  logic                  req0,
    input  bus_pkg::op_t          op0,
    input  bus_pkg::addr_t        addr0,
    input  bus_pkg::data_t        wdata0,
    input  bus_pkg::dram_ctrl_t   ctrl0,
    output logic                  ack0,
    output bus_pkg::data_t        rdata0,
    input  logic                  req1,
    input  bus_pkg::op_t          op1,
    input  bus_pkg::addr_t        addr1,
    input  bus_pkg::data_t        wdata1,
    input  bus_pkg::dram_ctrl_t   ctrl1,
    output logic                  ack1,
    output bus_pkg::data_t        rdata1,
    output bus_pkg::addr_t        mem_addr,
    output bus_pkg::data_t        mem_wdata,
    output bus_pkg::dram_ctrl_t   dram_ctrl,
    output logic                  dram_le,
    output logic                  dram_we,
    input  logic                  dram_busy,
    input  bus_pkg::data_t        dram_rdata,
    output logic                  dat_le,
    output logic                  dat_we,
    input  logic                  dat_busy,
    input  bus_pkg::data_t        dat_rdata,
    output bus_pkg::core_id_t     grant,
    output logic                  grant_valid
);
    import bus_pkg::*;

    logic       job_req;
    logic       job_ack;
    core_id_t   job_core;
    op_t        job_op;
    addr_t      job_addr;
    data_t      job_wdata;
    dram_ctrl_t job_ctrl;
    logic       res_req;
    logic       res_ack;
    core_id_t   res_core;
    data_t      res_data;

    bus_arbiter u_arbiter (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .init_done (init_done),
        .req0      (req0),
        .req1      (req1),
        .op0       (op0),
        .op1       (op1),
        .addr0     (addr0),
        .addr1     (addr1),
        .wdata0    (wdata0),
        .wdata1    (wdata1),
        .ctrl0     (ctrl0),
        .ctrl1     (ctrl1),
        .ack0      (ack0),
        .ack1      (ack1),
        .job_req   (job_req),
        .job_core  (job_core),
        .job_op    (job_op),
        .job_addr  (job_addr),
        .job_wdata (job_wdata),
        .job_ctrl  (job_ctrl),
        .job_ack   (job_ack)
    );

    mem_sequencer u_sequencer (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .job_req     (job_req),
        .job_core    (job_core),
        .job_op      (job_op),
        .job_addr    (job_addr),
        .job_wdata   (job_wdata),
        .job_ctrl    (job_ctrl),
        .job_ack     (job_ack),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .dram_ctrl   (dram_ctrl),
        .dram_le     (dram_le),
        .dram_we     (dram_we),
        .dat_le      (dat_le),
        .dat_we      (dat_we),
        .dram_busy   (dram_busy),
        .dat_busy    (dat_busy),
        .dram_rdata  (dram_rdata),
        .dat_rdata   (dat_rdata),
        .res_req     (res_req),
        .res_core    (res_core),
        .res_data    (res_data),
        .res_ack     (res_ack),
        .grant       (grant),
        .grant_valid (grant_valid)
    );

    resp_router u_router (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .res_req  (res_req),
        .res_core (res_core),
        .res_data (res_data),
        .res_ack  (res_ack),
        .req0     (req0),
        .req1     (req1),
        .ack0     (ack0),
        .ack1     (ack1),
        .rdata0   (rdata0),
        .rdata1   (rdata1)
    );

endmodule

//--- resp_router.sv
/* response router
   steers a result to its core and runs that core's four-phase ack */
`timescale 1ns/1ps

module resp_router (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic                  res_req,
    input  bus_pkg::core_id_t     res_core,
    input  bus_pkg::data_t        res_data,
    output logic                  res_ack,
    input  logic                  req0,
    input  logic                  req1,
    output logic                  ack0,
    output logic                  ack1,
    output bus_pkg::data_t        rdata0,
    output bus_pkg::data_t        rdata1
);
    import bus_pkg::*;

    resp_state_t state;
    core_id_t    core_q;
    logic        take;
    logic        core_req;

    // no new result while an ack is still outstanding
    assign take     = (state == RESP_IDLE) && res_req && !res_ack;
    assign core_req = (core_q == 1'b1) ? req1 : req0;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state   <= RESP_IDLE;
            res_ack <= 1'b0;
            ack0    <= 1'b0;
            ack1    <= 1'b0;
            core_q  <= 1'b0;
        end else begin
            if (res_ack && !res_req) begin
                res_ack <= 1'b0;
            end
            case (state)
                RESP_IDLE: begin
                    if (take) begin
                        res_ack <= 1'b1;
                        core_q  <= res_core;
                        state   <= RESP_ACK;
                    end
                end
                RESP_ACK: begin
                    if (core_q == 1'b1) begin
                        ack1 <= 1'b1;
                    end else begin
                        ack0 <= 1'b1;
                    end
                    state <= RESP_RELEASE;
                end
                RESP_RELEASE: begin
                    if (!core_req) begin
                        ack0  <= 1'b0;
                        ack1  <= 1'b0;
                        state <= RESP_IDLE;
                    end
                end
                default: state <= RESP_IDLE;
            endcase
        end
    end

    // other core's rdata keeps its last value
    always_ff @(posedge CLK) begin
        if (take) begin
            if (res_core == 1'b1) begin
                rdata1 <= res_data;
            end else begin
                rdata0 <= res_data;
            end
        end
    end

    a_one_ack: assert property (
        @(posedge CLK) disable iff (!arst_n)
        !(ack0 && ack1)
    ) else $error("ack0 and ack1 high together");

endmodule

//--- mem_sequencer.sv
/* memory sequencer
   runs one job on the dram or data target via strobe/busy and returns a result */
`timescale 1ns/1ps

module mem_sequencer (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic                  job_req,
    input  bus_pkg::core_id_t     job_core,
    input  bus_pkg::op_t          job_op,
    input  bus_pkg::addr_t        job_addr,
    input  bus_pkg::data_t        job_wdata,
    input  bus_pkg::dram_ctrl_t   job_ctrl,
    output logic                  job_ack,
    output bus_pkg::addr_t        mem_addr,
    output bus_pkg::data_t        mem_wdata,
    output bus_pkg::dram_ctrl_t   dram_ctrl,
    output logic                  dram_le,
    output logic                  dram_we,
    output logic                  dat_le,
    output logic                  dat_we,
    input  logic                  dram_busy,
    input  logic                  dat_busy,
    input  bus_pkg::data_t        dram_rdata,
    input  bus_pkg::data_t        dat_rdata,
    output logic                  res_req,
    output bus_pkg::core_id_t     res_core,
    output bus_pkg::data_t        res_data,
    input  logic                  res_ack,
    output bus_pkg::core_id_t     grant,
    output logic                  grant_valid
);
    import bus_pkg::*;

    seq_state_t state;
    core_id_t   core_q;
    op_t        op_q;
    addr_t      addr_q;
    data_t      wdata_q;
    dram_ctrl_t ctrl_q;
    logic       strobe_on;
    logic       sel_busy;
    data_t      sel_rdata;

    // op bit 1 picks the data target
    assign sel_busy  = op_q[1] ? dat_busy : dram_busy;
    assign sel_rdata = op_q[1] ? dat_rdata : dram_rdata;

    always_comb begin
        dram_le = 1'b0;
        dram_we = 1'b0;
        dat_le  = 1'b0;
        dat_we  = 1'b0;
        if (strobe_on) begin
            case (op_q)
                OP_DRAM_RD: dram_le = 1'b1;
                OP_DRAM_WR: dram_we = 1'b1;
                OP_DATA_RD: dat_le  = 1'b1;
                OP_DATA_WR: dat_we  = 1'b1;
                default:    dram_le = 1'b0;
            endcase
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state     <= SEQ_IDLE;
            job_ack   <= 1'b0;
            strobe_on <= 1'b0;
            res_req   <= 1'b0;
        end else begin
            // close the job handshake independently of the memory access
            if (job_ack && !job_req) begin
                job_ack <= 1'b0;
            end
            case (state)
                SEQ_IDLE: begin
                    if (job_req && !job_ack) begin
                        job_ack <= 1'b1;
                        state   <= SEQ_STROBE;
                    end
                end
                SEQ_STROBE: begin
                    if (!strobe_on) begin
                        strobe_on <= 1'b1;
                    end else if (sel_busy) begin
                        strobe_on <= 1'b0;
                        state     <= SEQ_WAIT;
                    end
                end
                SEQ_WAIT: begin
                    if (!sel_busy) begin
                        res_req <= 1'b1;
                        state   <= SEQ_DONE;
                    end
                end
                SEQ_DONE: begin
                    // held here while the response stage is back-pressured
                    if (res_req && res_ack) begin
                        res_req <= 1'b0;
                    end else if (!res_req && !res_ack) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == SEQ_IDLE && job_req && !job_ack) begin
            core_q  <= job_core;
            op_q    <= job_op;
            addr_q  <= job_addr;
            wdata_q <= job_wdata;
            ctrl_q  <= job_ctrl;
        end
        if (state == SEQ_WAIT && !sel_busy) begin
            // writes return zero
            res_data <= op_q[0] ? '0 : sel_rdata;
        end
    end

    assign mem_addr    = addr_q;
    assign mem_wdata   = wdata_q;
    assign dram_ctrl   = ctrl_q;
    assign res_core    = core_q;
    assign grant       = core_q;
    assign grant_valid = (state != SEQ_IDLE);

    a_one_strobe: assert property (
        @(posedge CLK) disable iff (!arst_n)
        $onehot0({dram_le, dram_we, dat_le, dat_we})
    ) else $error("more than one memory strobe high");

endmodule

//--- bus_arbiter.sv
/* round-robin bus arbiter
   picks one pending core request and hands it to the sequencer as a job */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic                  init_done,
    input  logic                  req0,
    input  logic                  req1,
    input  bus_pkg::op_t          op0,
    input  bus_pkg::op_t          op1,
    input  bus_pkg::addr_t        addr0,
    input  bus_pkg::addr_t        addr1,
    input  bus_pkg::data_t        wdata0,
    input  bus_pkg::data_t        wdata1,
    input  bus_pkg::dram_ctrl_t   ctrl0,
    input  bus_pkg::dram_ctrl_t   ctrl1,
    input  logic                  ack0,
    input  logic                  ack1,
    output logic                  job_req,
    output bus_pkg::core_id_t     job_core,
    output bus_pkg::op_t          job_op,
    output bus_pkg::addr_t        job_addr,
    output bus_pkg::data_t        job_wdata,
    output bus_pkg::dram_ctrl_t   job_ctrl,
    input  logic                  job_ack
);
    import bus_pkg::*;

    // per core: captured, not yet released by a falling ack
    logic [1:0] in_flight;
    logic [1:0] ack_q;
    logic [1:0] ack_fall;
    logic [1:0] elig;
    logic [1:0] grab;
    core_id_t   last;
    core_id_t   pick;
    logic       capture;

    assign ack_fall = ack_q & ~{ack1, ack0};
    assign elig     = {req1 & ~in_flight[1], req0 & ~in_flight[0]};

    always_comb begin
        if (elig == 2'b11) begin
            // contention, favour the core not served last
            pick = ~last;
        end else begin
            pick = core_id_t'(elig[1]);
        end
    end

    // slot is free only once the previous job handshake has fully closed
    assign capture = init_done && !job_req && !job_ack && (elig != 2'b00);
    assign grab    = capture ? ((pick == 1'b1) ? 2'b10 : 2'b01) : 2'b00;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            job_req   <= 1'b0;
            last      <= 1'b1;
            in_flight <= 2'b00;
            ack_q     <= 2'b00;
        end else begin
            ack_q     <= {ack1, ack0};
            in_flight <= (in_flight & ~ack_fall) | grab;
            if (capture) begin
                job_req <= 1'b1;
                last    <= pick;
            end else if (job_req && job_ack) begin
                job_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (capture) begin
            job_core <= pick;
            if (pick == 1'b1) begin
                job_op    <= op1;
                job_addr  <= addr1;
                job_wdata <= wdata1;
                job_ctrl  <= ctrl1;
            end else begin
                job_op    <= op0;
                job_addr  <= addr0;
                job_wdata <= wdata0;
                job_ctrl  <= ctrl0;
            end
        end
    end

    // sequencer may sample the fields any time before it acks
    a_job_stable: assert property (
        @(posedge CLK) disable iff (!arst_n)
        job_req |=> !job_req || $stable({job_core, job_op, job_addr, job_wdata, job_ctrl})
    ) else $error("job fields changed while job_req high");

endmodule

//--- bus_pkg.sv
/* bus subsystem shared types
   widths, operation codes and FSM state encodings for the two-core memory bus */
package bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int CTRL_W = 3;
    localparam int OP_W   = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    // size and sign of a dram access, passed through untouched
    typedef logic [CTRL_W-1:0] dram_ctrl_t;
    typedef logic [OP_W-1:0]   op_t;
    typedef logic [0:0]        core_id_t;

    // bit 1 selects data space, bit 0 marks a write
    localparam op_t OP_DRAM_RD = 2'd0;
    localparam op_t OP_DRAM_WR = 2'd1;
    localparam op_t OP_DATA_RD = 2'd2;
    localparam op_t OP_DATA_WR = 2'd3;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_STROBE,
        SEQ_WAIT,
        SEQ_DONE
    } seq_state_t;

    typedef enum logic [1:0] {
        RESP_IDLE,
        RESP_ACK,
        RESP_RELEASE
    } resp_state_t;

endpackage
